// ==== tb.f ====
logic/blk_mem_pkg.sv
logic/axil_pkg.sv
logic/word_ram.sv
logic/block_ram_port.sv
logic/axil_block_regs.sv
logic/block_mem_top.sv
verif/block_mem_props.sv
verif/block_mem_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := block_mem_tb
RTL_TOP    := block_mem_top
FILELIST   := tb.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
PASS_MSG   := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The pipeline status is that of grep, so a missing pass line fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/block_mem_tb.sv ====
`timescale 1ns/1ps

module block_mem_tb
    import blk_mem_pkg::*;
    import axil_pkg::*;
();

    localparam int BLK_ADDR_W = 11;
    // Block commands issued over the run, rejected ones included
    localparam int NUM_OPS = 22;

    logic                  clk;
    logic                  rst;
    logic                  awvalid;
    logic                  awready;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  wvalid;
    logic                  wready;
    word_t                 wdata;
    logic [3:0]            wstrb;
    logic                  bvalid;
    logic                  bready;
    resp_t                 bresp;
    logic                  arvalid;
    logic                  arready;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  rvalid;
    logic                  rready;
    word_t                 rdata;
    resp_t                 rresp;

    // Expected line per block address, and the line last staged
    line_t model [1 << BLK_ADDR_W];
    line_t staging;

    block_mem_top #(.BLK_ADDR_W(BLK_ADDR_W)) block_mem_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////
    // Failure handling

    task automatic fail_run();
        $display("ERRORS FOUND");
        $fatal(1, "Stopping after a failed check");
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
        fail_run();
    endtask

    initial begin
        repeat (200 * NUM_OPS) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a transfer never completed", 200 * NUM_OPS);
        fail_run();
    end

    ////////////////////
    // AXI4-Lite driver

    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input word_t data,
                             input logic [3:0] strb, input resp_t exp_resp);
        resp_t resp;
        @(posedge clk);
        #1;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        @(negedge clk);
        while (!(awready && wready)) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid) begin
            @(negedge clk);
        end
        // Random stall before taking the response
        repeat ($urandom % 4) @(posedge clk);
        @(posedge clk);
        #1;
        bready = 1'b1;
        @(negedge clk);
        resp = bresp;
        @(posedge clk);
        #1;
        bready = 1'b0;
        assert (resp == exp_resp) else report_mismatch("bresp", 32'(resp), 32'(exp_resp));
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output word_t data,
                            output resp_t resp);
        @(posedge clk);
        #1;
        arvalid = 1'b1;
        araddr  = addr;
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) begin
            @(negedge clk);
        end
        repeat ($urandom % 4) @(posedge clk);
        @(posedge clk);
        #1;
        rready = 1'b1;
        @(negedge clk);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    ////////////////////
    // Block level tasks

    function automatic line_t random_line();
        line_t line;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line[i] = $urandom;
        end
        return line;
    endfunction

    task automatic load_line(input line_t line);
        for (int i = 0; i < LINE_WORDS; i++) begin
            axi_write(REG_LINE0 + AXI_ADDR_W'(4 * i), line[i], 4'hF, RESP_OKAY);
        end
        staging = line;
    endtask

    // Poll STATUS until busy drops, return the last status word
    task automatic wait_idle(output word_t status);
        resp_t resp;
        do begin
            axi_read(REG_STATUS, status, resp);
            assert (resp == RESP_OKAY) else report_mismatch("rresp", 32'(resp), 32'(RESP_OKAY));
        end while (status[0]);
    endtask

    task automatic run_block(input logic [BLK_ADDR_W-1:0] addr, input blk_op_t op,
                             output word_t status);
        axi_write(REG_ADDR, WORD_W'(addr), 4'hF, RESP_OKAY);
        axi_write(REG_CMD, WORD_W'(op), 4'hF, RESP_OKAY);
        wait_idle(status);
    endtask

    task automatic write_block(input logic [BLK_ADDR_W-1:0] addr);
        word_t status;
        run_block(addr, OP_WRITE, status);
        model[addr] = staging;
    endtask

    // Read a block back, check the hit flag and every word
    task automatic check_block(input logic [BLK_ADDR_W-1:0] addr, input logic exp_hit);
        word_t status;
        word_t data;
        resp_t resp;
        run_block(addr, OP_READ, status);
        assert (status[1] == exp_hit)
            else report_mismatch("status.hit", 32'(status[1]), 32'(exp_hit));
        for (int i = 0; i < LINE_WORDS; i++) begin
            axi_read(REG_LINE0 + AXI_ADDR_W'(4 * i), data, resp);
            assert (resp == RESP_OKAY) else report_mismatch("rresp", 32'(resp), 32'(RESP_OKAY));
            assert (data == model[addr][i]) else report_mismatch("rdata", data, model[addr][i]);
        end
    endtask

    ////////////////////
    // Test sequence

    initial begin
        logic [BLK_ADDR_W-1:0] addrs [4];
        word_t                 status;
        word_t                 data;
        resp_t                 resp;
        void'($urandom(32'h4b0b_5da7));
        addrs   = '{11'h000, 11'h005, 11'h7FF, 11'h123};
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Separate lines at separate addresses
        foreach (addrs[i]) begin
            load_line(random_line());
            write_block(addrs[i]);
        end
        foreach (addrs[i]) begin
            check_block(addrs[i], 1'b0);
        end

        // Repeated read hits, any write clears the record
        check_block(addrs[3], 1'b1);
        check_block(addrs[3], 1'b1);
        load_line(random_line());
        write_block(addrs[1]);
        check_block(addrs[3], 1'b0);
        check_block(addrs[1], 1'b0);
        check_block(addrs[1], 1'b1);

        // Command while busy is refused
        load_line(random_line());
        axi_write(REG_ADDR, WORD_W'(addrs[2]), 4'hF, RESP_OKAY);
        axi_write(REG_CMD, WORD_W'(OP_WRITE), 4'hF, RESP_OKAY);
        axi_write(REG_CMD, WORD_W'(OP_READ), 4'hF, RESP_SLVERR);
        wait_idle(status);
        model[addrs[2]] = staging;

        // Unmapped offsets
        axi_write(8'h40, 32'hDEAD_BEEF, 4'hF, RESP_SLVERR);
        axi_read(8'h2C, data, resp);
        assert (resp == RESP_SLVERR) else report_mismatch("rresp", 32'(resp), 32'(RESP_SLVERR));

        // Partial strobes touch neither staging, address nor command
        axi_write(REG_LINE0, ~staging[0], 4'h3, RESP_SLVERR);
        axi_write(REG_ADDR, WORD_W'(addrs[0]), 4'h1, RESP_SLVERR);
        axi_write(REG_CMD, WORD_W'(OP_WRITE), 4'h7, RESP_SLVERR);
        axi_write(REG_CMD, WORD_W'(OP_WRITE), 4'hF, RESP_OKAY);
        wait_idle(status);
        model[addrs[2]] = staging;
        foreach (addrs[i]) begin
            check_block(addrs[i], 1'b0);
        end

        if (block_mem_top_i.props_i.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", block_mem_top_i.props_i.fail_count);
            fail_run();
        end
    end

endmodule

// ==== verif/block_mem_props.sv ====
`timescale 1ns/1ps

module block_mem_props
    import blk_mem_pkg::*;
    import axil_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    awready,
    input logic    wready,
    input logic    arready,
    input logic    bvalid,
    input logic    bready,
    input resp_t   bresp,
    input logic    rvalid,
    input logic    rready,
    input word_t   rdata,
    input resp_t   rresp,
    input logic    start,
    input blk_op_t op,
    input logic    busy,
    input logic    done,
    input logic    hit
);

    // Read by the testbench at the end of the run
    int unsigned fail_count = 0;

    ////////////////////
    // AXI4-Lite side

    ready_low_in_reset: assert property (@(posedge clk) rst |-> !awready && !wready && !arready)
        else begin fail_count++; $error("AXI ready high during reset"); end

    quiet_after_reset: assert property (
        @(posedge clk) rst |=> !bvalid && !rvalid && !start && !done && !busy
    ) else begin fail_count++; $error("Valid, start, done or busy high after a reset cycle"); end

    // Responses hold under back-pressure
    b_stable: assert property (
        @(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid && $stable(bresp)
    ) else begin fail_count++; $error("Write response changed while stalled"); end

    r_stable: assert property (
        @(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    ) else begin fail_count++; $error("Read response changed while stalled"); end

    ////////////////////
    // Block port

    no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else begin fail_count++; $error("Start issued while busy"); end

    write_done_9: assert property (
        @(posedge clk) disable iff (rst)
        $past(start, 9) && $past(op, 9) == OP_WRITE |-> done && !hit
    ) else begin fail_count++; $error("Block write did not finish 9 cycles after start"); end

    // A hit start has its done one cycle later, so skip those here
    miss_done_10: assert property (
        @(posedge clk) disable iff (rst)
        $past(start, 10) && $past(op, 10) == OP_READ && !$past(done, 9) |-> done && !hit
    ) else begin fail_count++; $error("Read miss did not finish 10 cycles after start"); end

    hit_done_1: assert property (@(posedge clk) disable iff (rst) done && hit |-> $past(start))
        else begin fail_count++; $error("Hit done not one cycle after start"); end

    no_early_done: assert property (
        @(posedge clk) disable iff (rst)
        done && !hit |-> ($past(start, 9) && $past(op, 9) == OP_WRITE) ||
                         ($past(start, 10) && $past(op, 10) == OP_READ)
    ) else begin fail_count++; $error("Done at a cycle that matches no start"); end

endmodule

bind block_mem_top block_mem_props props_i (
    .clk     (clk),
    .rst     (rst),
    .awready (awready),
    .wready  (wready),
    .arready (arready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .start   (start),
    .op      (op),
    .busy    (busy),
    .done    (done),
    .hit     (hit)
);

// ==== logic/block_mem_top.sv ====
`timescale 1ns/1ps

module block_mem_top
    import blk_mem_pkg::*;
    import axil_pkg::*;
#(
    parameter int BLK_ADDR_W = 11
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [AXI_ADDR_W-1:0] awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  word_t                 wdata,
    input  logic [3:0]            wstrb,
    output logic                  bvalid,
    input  logic                  bready,
    output resp_t                 bresp,
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [AXI_ADDR_W-1:0] araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output word_t                 rdata,
    output resp_t                 rresp
);

    // Register block to block port
    logic                  start;
    blk_op_t               op;
    logic [BLK_ADDR_W-1:0] blk_addr;
    line_t                 wr_line;
    logic                  busy;
    logic                  done;
    logic                  hit;
    line_t                 rd_line;

    // Block port to word RAM
    logic                             ram_en;
    logic                             ram_we;
    logic [BLK_ADDR_W+WORD_IDX_W-1:0] ram_addr;
    word_t                            ram_wdata;
    word_t                            ram_rdata;

    axil_block_regs #(
        .BLK_ADDR_W(BLK_ADDR_W)
    ) u_regs (
        .clk      (clk),
        .rst      (rst),
        .awvalid  (awvalid),
        .awready  (awready),
        .awaddr   (awaddr),
        .wvalid   (wvalid),
        .wready   (wready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .rvalid   (rvalid),
        .rready   (rready),
        .rdata    (rdata),
        .rresp    (rresp),
        .start    (start),
        .op       (op),
        .blk_addr (blk_addr),
        .wr_line  (wr_line),
        .busy     (busy),
        .done     (done),
        .hit      (hit),
        .rd_line  (rd_line)
    );

    block_ram_port #(
        .BLK_ADDR_W(BLK_ADDR_W)
    ) u_port (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .op        (op),
        .blk_addr  (blk_addr),
        .wr_line   (wr_line),
        .busy      (busy),
        .done      (done),
        .hit       (hit),
        .rd_line   (rd_line),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    word_ram #(
        .BLK_ADDR_W(BLK_ADDR_W)
    ) u_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

// ==== logic/axil_block_regs.sv ====
`timescale 1ns/1ps

module axil_block_regs
    import blk_mem_pkg::*;
    import axil_pkg::*;
#(
    parameter int BLK_ADDR_W = 11
) (
    input  logic                  clk,
    input  logic                  rst,

    // AXI4-Lite write side
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [AXI_ADDR_W-1:0] awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  word_t                 wdata,
    input  logic [3:0]            wstrb,
    output logic                  bvalid,
    input  logic                  bready,
    output resp_t                 bresp,

    // AXI4-Lite read side
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [AXI_ADDR_W-1:0] araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output word_t                 rdata,
    output resp_t                 rresp,

    // Block port
    output logic                  start,
    output blk_op_t               op,
    output logic [BLK_ADDR_W-1:0] blk_addr,
    output line_t                 wr_line,
    input  logic                  busy,
    input  logic                  done,
    input  logic                  hit,
    input  line_t                 rd_line
);

    logic aw_hs;
    logic ar_hs;

    logic w_is_line;
    logic w_is_addr;
    logic w_is_cmd;
    logic w_ok;

    word_t r_word;
    logic  r_ok;

    // Set by an accepted command, cleared by its done
    logic op_pend;
    logic hit_last;

    ////////////////////
    // Handshakes

    assign aw_hs   = awvalid && wvalid && !bvalid;
    assign awready = aw_hs;
    assign wready  = aw_hs;

    assign ar_hs   = arvalid && !rvalid;
    assign arready = ar_hs;

    ////////////////////
    // Write decode

    // Line offsets differ only in the bits set in REG_LINE7
    assign w_is_line = (awaddr & ~REG_LINE7) == REG_LINE0;
    assign w_is_addr = awaddr == REG_ADDR;
    assign w_is_cmd  = (awaddr == REG_CMD) && !(op_pend || busy);
    assign w_ok      = (wstrb == 4'hF) && (w_is_line || w_is_addr || w_is_cmd);

    // Read mux
    always_comb begin
        r_word = '0;
        r_ok   = 1'b1;
        if ((araddr & ~REG_LINE7) == REG_LINE0) begin
            r_word = rd_line[araddr[2 +: WORD_IDX_W]];
        end else begin
            case (araddr)
                REG_ADDR:   r_word = WORD_W'(blk_addr);
                REG_CMD:    r_word = WORD_W'(op);
                REG_STATUS: r_word = {{(WORD_W-2){1'b0}}, hit_last, op_pend || busy};
                default:    r_ok = 1'b0;
            endcase
        end
    end

    ////////////////////
    // Control registers

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
            start    <= 1'b0;
            op       <= OP_READ;
            blk_addr <= '0;
            op_pend  <= 1'b0;
            hit_last <= 1'b0;
        end else begin
            start <= 1'b0;

            if (done) begin
                op_pend  <= 1'b0;
                hit_last <= hit;
            end

            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (aw_hs) begin
                bvalid <= 1'b1;
                if (w_ok && w_is_addr) begin
                    blk_addr <= wdata[BLK_ADDR_W-1:0];
                end
                // Start goes out the cycle after the command is accepted
                if (w_ok && w_is_cmd) begin
                    start   <= 1'b1;
                    op      <= blk_op_t'(wdata[0]);
                    op_pend <= 1'b1;
                end
            end

            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (ar_hs) begin
                rvalid <= 1'b1;
            end
        end
    end

    // Staging line and response payload
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            bresp <= w_ok ? RESP_OKAY : RESP_SLVERR;
            if (w_ok && w_is_line) begin
                wr_line[awaddr[2 +: WORD_IDX_W]] <= wdata;
            end
        end
        if (ar_hs) begin
            rdata <= r_word;
            rresp <= r_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

// ==== logic/block_ram_port.sv ====
`timescale 1ns/1ps

module block_ram_port
    import blk_mem_pkg::*;
#(
    parameter int BLK_ADDR_W = 11
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  blk_op_t                          op,
    input  logic [BLK_ADDR_W-1:0]            blk_addr,
    input  line_t                            wr_line,
    output logic                             busy,
    output logic                             done,
    output logic                             hit,
    output line_t                            rd_line,
    output logic                             ram_en,
    output logic                             ram_we,
    output logic [BLK_ADDR_W+WORD_IDX_W-1:0] ram_addr,
    output word_t                            ram_wdata,
    input  word_t                            ram_rdata
);

    localparam int CNT_W = WORD_IDX_W + 1;

    // Counts 0..7 while words go out, 8 is the extra read drain cycle
    logic [CNT_W-1:0]      count;
    blk_op_t               cur_op;
    logic [BLK_ADDR_W-1:0] cur_addr;

    // Last completed read
    logic [BLK_ADDR_W-1:0] last_addr;
    logic                  hit_valid;

    // Word returning from the RAM this cycle
    logic                  cap_vld;
    logic [WORD_IDX_W-1:0] cap_idx;

    logic is_hit;
    logic last_step;

    ////////////////////
    // RAM side

    assign ram_en    = busy && !count[WORD_IDX_W];
    assign ram_we    = ram_en && (cur_op == OP_WRITE);
    assign ram_addr  = {cur_addr, count[WORD_IDX_W-1:0]};
    assign ram_wdata = wr_line[count[WORD_IDX_W-1:0]];

    // A repeated read is served from the line buffer
    assign is_hit = (op == OP_READ) && hit_valid && (blk_addr == last_addr);

    // Writes end with word 7, reads wait one more cycle for its data
    assign last_step = (cur_op == OP_WRITE) ? (count == CNT_W'(LINE_WORDS - 1))
                                            : (count == CNT_W'(LINE_WORDS));

    ////////////////////
    // Control

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            hit       <= 1'b0;
            count     <= '0;
            hit_valid <= 1'b0;
            cap_vld   <= 1'b0;
        end else begin
            done    <= 1'b0;
            hit     <= 1'b0;
            cap_vld <= ram_en && !ram_we;
            if (start && !busy) begin
                if (is_hit) begin
                    done <= 1'b1;
                    hit  <= 1'b1;
                end else begin
                    busy  <= 1'b1;
                    count <= '0;
                    // Any write makes the buffered line stale
                    if (op == OP_WRITE) begin
                        hit_valid <= 1'b0;
                    end
                end
            end else if (busy) begin
                count <= count + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    if (cur_op == OP_READ) begin
                        hit_valid <= 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////
    // Operation and line data

    always_ff @(posedge clk) begin
        if (start && !busy && !is_hit) begin
            cur_op   <= op;
            cur_addr <= blk_addr;
        end
        if (busy && last_step && cur_op == OP_READ) begin
            last_addr <= cur_addr;
        end
        cap_idx <= count[WORD_IDX_W-1:0];
        if (cap_vld) begin
            rd_line[cap_idx] <= ram_rdata;
        end
    end

endmodule

// ==== logic/word_ram.sv ====
`timescale 1ns/1ps

module word_ram
    import blk_mem_pkg::*;
#(
    parameter int BLK_ADDR_W = 11
) (
    input  logic                             clk,
    input  logic                             en,
    input  logic                             we,
    input  logic [BLK_ADDR_W+WORD_IDX_W-1:0] addr,
    input  word_t                            wdata,
    output word_t                            rdata
);

    // One line per block address, eight words per line
    localparam int DEPTH = LINE_WORDS * (1 << BLK_ADDR_W);

    word_t mem [DEPTH];

    // No-change mode, a write keeps the last read word on rdata
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// ==== logic/axil_pkg.sv ====
package axil_pkg;

    localparam int AXI_ADDR_W = 8;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_t;

    ////////////////////
    // Control block register map

    // Staging line, one word per offset
    localparam logic [AXI_ADDR_W-1:0] REG_LINE0  = 8'h00;
    localparam logic [AXI_ADDR_W-1:0] REG_LINE1  = 8'h04;
    localparam logic [AXI_ADDR_W-1:0] REG_LINE2  = 8'h08;
    localparam logic [AXI_ADDR_W-1:0] REG_LINE3  = 8'h0C;
    localparam logic [AXI_ADDR_W-1:0] REG_LINE4  = 8'h10;
    localparam logic [AXI_ADDR_W-1:0] REG_LINE5  = 8'h14;
    localparam logic [AXI_ADDR_W-1:0] REG_LINE6  = 8'h18;
    localparam logic [AXI_ADDR_W-1:0] REG_LINE7  = 8'h1C;
    localparam logic [AXI_ADDR_W-1:0] REG_ADDR   = 8'h20;
    localparam logic [AXI_ADDR_W-1:0] REG_CMD    = 8'h24;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 8'h28;

endpackage

// ==== logic/blk_mem_pkg.sv ====
package blk_mem_pkg;

    ////////////////////
    // Word and line geometry

    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 8;

    // Bits needed to pick one word out of a line
    localparam int WORD_IDX_W = $clog2(LINE_WORDS);

    typedef logic [WORD_W-1:0] word_t;

    // Word 0 sits in the low bits of the line
    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

    ////////////////////
    // Block operation code

    // Matches bit 0 of the command register
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } blk_op_t;

endpackage
